//--- tests/wb_stage_tb.sv
`include "wb_config.svh"

module wb_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import wb_pkg::*;

    localparam word_t STATUS_WR = 32'h0000_ff03; // IM, EXL, IE

    typedef struct packed {
        word_t     status;
        word_t     epc;
        word_t     badvaddr;
        logic      bd;
        exc_code_t exc;
        irq_t      ip;
    } cp0_model_t;

    typedef struct packed {
        int        due;   // cycle count at which the check applies
        rf_write_t wr;
        logic      flush;
        word_t     pc;
    } expect_t;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    wb_item_t   in_item;
    irq_t       ext_int;
    rf_write_t  rf_wr;
    logic       int_pending;
    logic       flush;
    wb_trace_t  trace;

    cp0_model_t model;
    expect_t    wr_q[$];
    expect_t    tr_q[$];
    int         cyc = 0;
    int         err_count = 0;
    int         tests_ok = 0;
    int         tests_bad = 0;
    integer     seed;

    wb_stage dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_item     (in_item),
        .ext_int     (ext_int),
        .rf_wr       (rf_wr),
        .int_pending (int_pending),
        .flush       (flush),
        .trace       (trace)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic rf_write_t expected_write(wb_item_t it, cp0_model_t m);
        rf_write_t   r;
        logic [7:0]  b;
        logic [15:0] h;
        int          s;
        int          i;
        r       = '0;
        r.wnum  = it.wnum;
        b       = it.dm_data >> (8 * it.addr_lo);      // byte at addr_lo
        h       = it.dm_data >> (16 * it.addr_lo[1]);  // halfword at addr_lo[1]
        case (it.src)
            src_alu: begin
                r.we    = 4'hf;
                r.wdata = it.alu_data;
            end
            src_load: begin
                r.we = 4'hf;
                case (it.kind)
                    ld_byte:   r.wdata = 32'($signed(b));
                    ld_byte_u: r.wdata = 32'(b);
                    ld_half:   r.wdata = 32'($signed(h));
                    ld_half_u: r.wdata = 32'(h);
                    default:   r.wdata = it.dm_data;
                endcase
            end
            src_merge: begin
                // right rotation by 8*a is a left rotation by 32 - 8*a
                s = it.merge_left ? 8 * (3 - it.addr_lo) : 32 - 8 * it.addr_lo;
                r.wdata = (it.dm_data << s) | (it.dm_data >> (32 - s));
                for (i = 0; i < 4; i++) begin
                    r.we[i] = it.merge_left ? (i >= 3 - it.addr_lo) : (i < 4 - it.addr_lo);
                end
            end
            src_cp0: begin
                r.we = 4'hf;
                case (it.cp0_addr)
                    `CP0_STATUS:   r.wdata = m.status;
                    `CP0_EPC:      r.wdata = m.epc;
                    `CP0_BADVADDR: r.wdata = m.badvaddr;
                    `CP0_CAUSE: begin
                        r.wdata[31]    = m.bd;
                        r.wdata[15:10] = m.ip;
                        r.wdata[6:2]   = m.exc;
                    end
                    default: r.wdata = '0;
                endcase
            end
            default: r.we = 4'h0;
        endcase
        if (it.exc) begin
            r.we = 4'h0; // faulting item retires nothing
        end
        return r;
    endfunction

    task automatic update_cp0(wb_item_t it);
        if (it.exc) begin
            model.status[1] = 1'b1;
            model.bd        = it.bd;
            model.exc       = it.exc_code;
            model.epc       = it.bd ? it.pc - 32'd4 : it.pc;
            if (it.exc_code == `EXC_ADEL || it.exc_code == `EXC_ADES) begin
                model.badvaddr = it.bad_vaddr;
            end
        end else if (it.eret) begin
            model.status[1] = 1'b0;
        end else if (it.mtc0 && it.cp0_addr == `CP0_STATUS) begin
            model.status = (model.status & ~STATUS_WR) | (it.alu_data & STATUS_WR);
        end else if (it.mtc0 && it.cp0_addr == `CP0_EPC) begin
            model.epc = it.alu_data;
        end
    endtask

    // --------------------------------------------------
    // checks and comparator
    // --------------------------------------------------
    task automatic check_value(string name, word_t got, word_t exp);
        assert (got === exp) else begin
            $display("Error: %s = %0h, expected %0h", name, got, exp);
            err_count++;
        end
    endtask

    always @(negedge clk) begin : compare
        expect_t e;
        if (tr_q.size() > 0 && tr_q[0].due == cyc) begin
            e = tr_q.pop_front();
            check_value("trace.wen", trace.wen, e.wr.we);
            if (e.wr.we != 4'h0) begin
                check_value("trace.pc", trace.pc, e.pc);
                check_value("trace.wnum", trace.wnum, e.wr.wnum);
                check_value("trace.wdata", trace.wdata, e.wr.wdata);
            end
        end
        if (wr_q.size() > 0 && wr_q[0].due == cyc) begin
            e = wr_q.pop_front();
            check_value("rf_wr.we", rf_wr.we, e.wr.we);
            if (e.wr.we != 4'h0) begin
                check_value("rf_wr.wnum", rf_wr.wnum, e.wr.wnum);
                check_value("rf_wr.wdata", rf_wr.wdata, e.wr.wdata);
            end
            check_value("flush", flush, e.flush);
            e.due = cyc + 1; // trace lags one more edge
            tr_q.push_back(e);
        end
    end

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    task automatic issue(wb_item_t it);
        expect_t e;
        @(negedge clk);
        in_valid = 1'b1;
        in_item  = it;
        model.ip = ext_int; // cause samples the lines at the same edge
        e       = '0;
        e.due   = cyc + 1;
        e.wr    = expected_write(it, model);
        e.flush = it.exc || it.eret;
        e.pc    = it.pc;
        wr_q.push_back(e);
        update_cp0(it);
    endtask

    task automatic idle();
        expect_t e;
        @(negedge clk);
        in_valid = 1'b0;
        in_item  = '0;
        model.ip = ext_int;
        e        = '0;
        e.due    = cyc + 1;
        wr_q.push_back(e);
    endtask

    function automatic wb_item_t rand_item(wb_src_e src);
        wb_item_t it;
        it          = '0;
        it.pc       = $random(seed);
        it.pc[1:0]  = 2'b00;
        it.dm_data  = $random(seed);
        it.alu_data = $random(seed);
        it.wnum     = $random(seed);
        it.src      = src;
        return it;
    endfunction

    function automatic wb_item_t move_to(cp0_addr_t addr, word_t val);
        wb_item_t it;
        it          = rand_item(src_none);
        it.mtc0     = 1'b1;
        it.cp0_addr = addr;
        it.alu_data = val;
        return it;
    endfunction

    function automatic wb_item_t move_from(cp0_addr_t addr);
        wb_item_t it;
        it          = rand_item(src_cp0);
        it.cp0_addr = addr;
        return it;
    endfunction

    task automatic wait_drain();
        int n;
        n = 0;
        while ((wr_q.size() > 0 || tr_q.size() > 0) && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (wr_q.size() > 0 || tr_q.size() > 0) begin
            $display("timeout: %0d expected results never came due", wr_q.size() + tr_q.size());
            err_count++;
            wr_q.delete();
            tr_q.delete();
        end
    endtask

    task automatic wait_pending(logic want, string what);
        int n;
        n = 0;
        idle();
        while (int_pending !== want && n < 8) begin
            idle();
            n++;
        end
        assert (int_pending === want) else begin
            $display("timeout: int_pending never went to %0b %s", want, what);
            err_count++;
        end
    endtask

    task automatic test_done(string name, int errs_before);
        wait_drain();
        if (err_count == errs_before) begin
            tests_ok++;
            $display("test %s: passed", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        wb_item_t it;
        int       e0;
        seed         = 79132;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_item      = '0;
        ext_int      = '0;
        model        = '0;
        model.status = `STATUS_RESET;
        repeat (4) @(negedge clk);

        e0 = err_count;
        check_value("rf_wr.we", rf_wr.we, 4'h0);
        check_value("flush", flush, 1'b0);
        check_value("int_pending", int_pending, 1'b0);
        check_value("trace.wen", trace.wen, 4'h0);
        rst_n = 1'b1;
        for (int i = 0; i < 16; i++) begin
            issue(rand_item(src_alu));
            if ($random(seed) % 2) begin
                idle(); // bubble between items
            end
        end
        idle();
        test_done("reset and alu pass-through", e0);

        e0 = err_count;
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 5; k++) begin
                for (int a = 0; a < 4; a++) begin
                    it         = rand_item(src_load);
                    it.kind    = load_kind_e'(k);
                    it.addr_lo = a;
                    if (k < 2 || (k < 4 && a % 2 == 0) || a == 0) begin
                        issue(it);
                    end
                end
            end
        end
        idle();
        test_done("partial loads", e0);

        e0 = err_count;
        for (int left = 0; left < 2; left++) begin
            for (int a = 0; a < 4; a++) begin
                it            = rand_item(src_merge);
                it.merge_left = left[0];
                it.addr_lo    = a;
                issue(it);
            end
        end
        idle();
        test_done("unaligned merge", e0);

        e0 = err_count;
        issue(move_to(`CP0_STATUS, $random(seed)));
        issue(move_from(`CP0_STATUS));
        issue(move_to(`CP0_EPC, $random(seed)));
        issue(move_from(`CP0_EPC));
        issue(move_from(5'd3)); // unmapped
        it          = move_to(`CP0_STATUS, $random(seed));
        it.src      = src_cp0;  // reads the old value in the same cycle
        it.wnum     = $random(seed);
        issue(it);
        issue(move_from(`CP0_STATUS));
        idle();
        test_done("move-to and move-from", e0);

        e0 = err_count;
        it           = rand_item(src_alu);
        it.exc       = 1'b1;
        it.bd        = 1'b1;
        it.exc_code  = `EXC_ADEL;
        it.bad_vaddr = $random(seed);
        issue(it);
        idle(); // flush must drop again
        issue(move_from(`CP0_EPC));
        issue(move_from(`CP0_CAUSE));
        issue(move_from(`CP0_BADVADDR));
        issue(move_from(`CP0_STATUS));
        it          = rand_item(src_load);
        it.exc      = 1'b1;
        it.exc_code = 5'd12;
        issue(it);
        idle();
        issue(move_from(`CP0_EPC));
        issue(move_from(`CP0_BADVADDR)); // unchanged by a non-address fault
        it      = rand_item(src_none);
        it.eret = 1'b1;
        issue(it);
        idle();
        issue(move_from(`CP0_STATUS));
        idle();
        test_done("exceptions and return", e0);

        e0 = err_count;
        issue(move_to(`CP0_STATUS, 32'h0000_1001)); // IE, IM for line 2
        wait_pending(1'b0, "with the line low");
        @(negedge clk);
        ext_int = 6'b000100;
        wait_pending(1'b1, "after raising line 2");
        issue(move_from(`CP0_CAUSE));
        issue(move_to(`CP0_STATUS, 32'h0000_0001));
        wait_pending(1'b0, "with line 2 masked");
        issue(move_to(`CP0_STATUS, 32'h0000_1001));
        wait_pending(1'b1, "after unmasking line 2");
        issue(move_to(`CP0_STATUS, 32'h0000_1003));
        wait_pending(1'b0, "with EXL set");
        idle();
        test_done("interrupt pending", e0);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_ok, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/cp0_regs.sv
`include "wb_config.svh"

module cp0_regs (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cur_valid,
    input  wb_pkg::wb_item_t cur_item,
    input  wb_pkg::irq_t     ext_int,
    output wb_pkg::word_t    rdata,
    output logic             int_pending
);

    import wb_pkg::*;

    word_t     status_q;
    logic      cause_bd;
    irq_t      cause_ip;
    exc_code_t cause_exc;
    word_t     epc_q;
    word_t     badvaddr_q;
    word_t     cause_word;

    logic take_exc;
    logic do_eret;
    logic do_mtc0;
    logic addr_err;

    // an exception in the same item overrides its move-to and return
    assign take_exc = cur_valid && cur_item.exc;
    assign do_eret  = cur_valid && cur_item.eret && !cur_item.exc;
    assign do_mtc0  = cur_valid && cur_item.mtc0 && !cur_item.exc;
    assign addr_err = (cur_item.exc_code == `EXC_ADEL) ||
                      (cur_item.exc_code == `EXC_ADES);

    // --------------------------------------------------
    // status and cause
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q <= `STATUS_RESET;
        end else if (take_exc) begin
            status_q[1] <= 1'b1; // EXL
        end else if (do_eret) begin
            status_q[1] <= 1'b0;
        end else if (do_mtc0 && cur_item.cp0_addr == `CP0_STATUS) begin
            status_q <= (status_q & ~`STATUS_WMASK) | (cur_item.alu_data & `STATUS_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cause_bd  <= 1'b0;
            cause_ip  <= '0;
            cause_exc <= '0;
        end else begin
            cause_ip <= ext_int; // sampled every edge
            if (take_exc) begin
                cause_bd  <= cur_item.bd;
                cause_exc <= cur_item.exc_code;
            end
        end
    end

    // --------------------------------------------------
    // epc and badvaddr
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (take_exc) begin
            // delay slot faults return to the branch
            epc_q <= cur_item.bd ? cur_item.pc - 32'd4 : cur_item.pc;
        end else if (do_mtc0 && cur_item.cp0_addr == `CP0_EPC) begin
            epc_q <= cur_item.alu_data;
        end
    end

    always_ff @(posedge clk) begin
        if (take_exc && addr_err) begin
            badvaddr_q <= cur_item.bad_vaddr; // read-only to software
        end
    end

    // --------------------------------------------------
    // read port and interrupt pending
    // --------------------------------------------------
    assign cause_word = {cause_bd, 15'd0, cause_ip, 3'd0, cause_exc, 2'd0};

    // old values, before this item's own update
    always_comb begin
        case (cur_item.cp0_addr)
            `CP0_BADVADDR: rdata = badvaddr_q;
            `CP0_STATUS:   rdata = status_q;
            `CP0_CAUSE:    rdata = cause_word;
            `CP0_EPC:      rdata = epc_q;
            default:       rdata = '0; // unmapped
        endcase
    end

    // hardware lines only: IP[15:10] against IM[15:10]
    assign int_pending = status_q[0] && !status_q[1] && |(cause_ip & status_q[15:10]);

    // a bubble from the latch never carries an exception
    a_no_exc_on_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        !cur_valid |-> !cur_item.exc
    ) else $error("exception entry without a valid item");

endmodule

//--- verilog/load_align.sv
module load_align (
    input  wb_pkg::word_t      word,
    input  logic [1:0]         addr_lo,
    input  wb_pkg::load_kind_e kind,
    output wb_pkg::word_t      data
);

    import wb_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // little-endian: byte 0 sits in bits 7:0
    always_comb begin
        case (addr_lo)
            2'd0:    byte_sel = word[7:0];
            2'd1:    byte_sel = word[15:8];
            2'd2:    byte_sel = word[23:16];
            default: byte_sel = word[31:24];
        endcase
        half_sel = addr_lo[1] ? word[31:16] : word[15:0];
    end

    // extend by kind
    always_comb begin
        case (kind)
            ld_byte:   data = {{24{byte_sel[7]}}, byte_sel};
            ld_byte_u: data = {24'd0, byte_sel};
            ld_half:   data = {{16{half_sel[15]}}, half_sel};
            ld_half_u: data = {16'd0, half_sel};
            default:   data = word; // ld_word
        endcase
    end

    // misaligned halfwords are caught as AdEL earlier in the pipe
    always_comb begin
        if (kind == ld_half || kind == ld_half_u) begin
            a_half_aligned: assert #0 (!addr_lo[0])
                else $error("halfword load with addr_lo = %0d", addr_lo);
        end
    end

endmodule

//--- verilog/load_merge.sv
module load_merge (
    input  wb_pkg::word_t    word,
    input  logic [1:0]       addr_lo,
    input  logic             merge_left,
    output wb_pkg::word_t    data,
    output wb_pkg::byte_en_t be
);

    import wb_pkg::*;

    logic [1:0] rot_bytes; // left rotation, in bytes
    word_t      rotated;
    byte_en_t   left_be;
    byte_en_t   right_be;

    // --------------------------------------------------
    // rotation amount
    // --------------------------------------------------
    // left:  rotl by 3 - addr_lo, which is ~addr_lo in two bits
    // right: rotr by addr_lo, the same as rotl by -addr_lo mod 4
    always_comb begin
        if (merge_left) begin
            rot_bytes = ~addr_lo;
        end else begin
            rot_bytes = 2'd0 - addr_lo;
        end
    end

    always_comb begin
        case (rot_bytes)
            2'd0:    rotated = word;
            2'd1:    rotated = {word[23:0], word[31:24]};
            2'd2:    rotated = {word[15:0], word[31:16]};
            default: rotated = {word[7:0], word[31:8]};
        endcase
    end

    // --------------------------------------------------
    // byte enables
    // --------------------------------------------------
    // load-left fills from the top down, addr_lo + 1 bytes
    assign left_be  = 4'b1111 << (2'd3 - addr_lo);
    // load-right fills from the bottom up, 4 - addr_lo bytes
    assign right_be = 4'b1111 >> addr_lo;

    assign data = rotated;
    assign be   = merge_left ? left_be : right_be;

endmodule

//--- verilog/wb_config.svh
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// --------------------------------------------------
// cp0 register numbers
// --------------------------------------------------
`define CP0_BADVADDR 5'd8
`define CP0_STATUS   5'd12
`define CP0_CAUSE    5'd13
`define CP0_EPC      5'd14

// --------------------------------------------------
// exception codes
// --------------------------------------------------
`define EXC_ADEL 5'd4 // address error on load or fetch
`define EXC_ADES 5'd5 // address error on store

// --------------------------------------------------
// reset values and masks
// --------------------------------------------------
`define STATUS_RESET 32'h0040_0000 // only BEV set

// IM[15:8], EXL[1], IE[0]
`define STATUS_WMASK 32'h0000_ff03

// trace register comes up with no write shown
`define TRACE_RESET 73'd0

`endif

//--- verilog/wb_input_latch.sv
module wb_input_latch (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  wb_pkg::wb_item_t in_item,
    output logic             cur_valid,
    output wb_pkg::wb_item_t cur_item
);

    // --------------------------------------------------
    // valid bit
    // --------------------------------------------------
    // stage is always ready, so every edge takes whatever is offered
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_valid <= 1'b0;
        end else begin
            cur_valid <= in_valid;
        end
    end

    // --------------------------------------------------
    // item register
    // --------------------------------------------------
    // a bubble loads an all-zero item: src_none, no exc, no mtc0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_item <= '0;
        end else if (!in_valid) begin
            cur_item <= '0; // idle cycle
        end else begin
            cur_item <= in_item;
        end
    end

    // a valid item never asks for an exception and a return at once
    a_item_sane: assert property (
        @(posedge clk) disable iff (!rst_n)
        cur_valid |-> !(cur_item.exc && cur_item.eret)
    ) else $error("valid item has exc and eret together");

endmodule

//--- verilog/wb_pkg.sv
package wb_pkg;

    // --------------------------------------------------
    // widths with a meaning
    // --------------------------------------------------
    typedef logic [31:0] word_t;     // data or address word
    typedef logic [4:0]  reg_num_t;  // register file index
    typedef logic [3:0]  byte_en_t;  // per-byte write enable
    typedef logic [4:0]  cp0_addr_t; // cp0 register number
    typedef logic [4:0]  exc_code_t;
    typedef logic [5:0]  irq_t;      // external interrupt lines

    // write-back source; src_none must stay 0 so a cleared item is idle
    typedef enum logic [2:0] {
        src_none  = 3'd0,
        src_alu   = 3'd1,
        src_load  = 3'd2,
        src_merge = 3'd3,
        src_cp0   = 3'd4
    } wb_src_e;

    typedef enum logic [2:0] {
        ld_byte   = 3'd0,
        ld_byte_u = 3'd1,
        ld_half   = 3'd2,
        ld_half_u = 3'd3,
        ld_word   = 3'd4
    } load_kind_e;

    // one result coming out of the memory stage
    typedef struct packed {
        word_t      pc;
        word_t      dm_data;    // raw memory word
        word_t      alu_data;   // also the move-to value
        reg_num_t   wnum;
        wb_src_e    src;
        load_kind_e kind;
        logic       merge_left; // 1 = load-left
        logic [1:0] addr_lo;
        logic       exc;
        logic       bd;         // in a branch delay slot
        exc_code_t  exc_code;
        word_t      bad_vaddr;
        cp0_addr_t  cp0_addr;
        logic       mtc0;
        logic       eret;
    } wb_item_t;

    typedef struct packed {
        byte_en_t we;
        reg_num_t wnum;
        word_t    wdata;
    } rf_write_t;

    typedef struct packed {
        word_t    pc;
        byte_en_t wen;
        reg_num_t wnum;
        word_t    wdata;
    } wb_trace_t;

endpackage

//--- verilog/wb_result_select.sv
`include "wb_config.svh"

module wb_result_select (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cur_valid,
    input  wb_pkg::wb_item_t  cur_item,
    input  wb_pkg::word_t     align_data,
    input  wb_pkg::word_t     merge_data,
    input  wb_pkg::byte_en_t  merge_be,
    input  wb_pkg::word_t     cp0_rdata,
    output wb_pkg::rf_write_t rf_wr,
    output logic              flush,
    output wb_pkg::wb_trace_t trace
);

    import wb_pkg::*;

    word_t    wdata;
    byte_en_t we;

    // --------------------------------------------------
    // write port
    // --------------------------------------------------
    always_comb begin
        case (cur_item.src)
            src_alu: begin
                wdata = cur_item.alu_data;
                we    = 4'hf;
            end
            src_load: begin
                wdata = align_data;
                we    = 4'hf;
            end
            src_merge: begin
                wdata = merge_data;
                we    = merge_be; // partial register update
            end
            src_cp0: begin
                wdata = cp0_rdata;
                we    = 4'hf;
            end
            default: begin
                wdata = cur_item.alu_data;
                we    = '0; // src_none
            end
        endcase
        // a faulting instruction must not retire its write
        if (!cur_valid || cur_item.exc) begin
            we = '0;
        end
    end

    assign rf_wr.we    = we;
    assign rf_wr.wnum  = cur_item.wnum;
    assign rf_wr.wdata = wdata;

    assign flush = cur_valid && (cur_item.exc || cur_item.eret);

    // --------------------------------------------------
    // debug trace, one edge behind the write
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trace <= `TRACE_RESET;
        end else begin
            trace.pc    <= cur_item.pc;
            trace.wen   <= rf_wr.we;
            trace.wnum  <= rf_wr.wnum;
            trace.wdata <= rf_wr.wdata;
        end
    end

endmodule

//--- verilog/wb_stage.sv
module wb_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  wb_pkg::wb_item_t  in_item,
    input  wb_pkg::irq_t      ext_int,
    output wb_pkg::rf_write_t rf_wr,
    output logic              int_pending,
    output logic              flush,
    output wb_pkg::wb_trace_t trace
);

    import wb_pkg::*;

    logic     cur_valid;
    wb_item_t cur_item;
    word_t    align_data;
    word_t    merge_data;
    byte_en_t merge_be;
    word_t    cp0_rdata;

    wb_input_latch u_latch (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_item   (in_item),
        .cur_valid (cur_valid),
        .cur_item  (cur_item)
    );

    load_align u_align (
        .word    (cur_item.dm_data),
        .addr_lo (cur_item.addr_lo),
        .kind    (cur_item.kind),
        .data    (align_data)
    );

    load_merge u_merge (
        .word       (cur_item.dm_data),
        .addr_lo    (cur_item.addr_lo),
        .merge_left (cur_item.merge_left),
        .data       (merge_data),
        .be         (merge_be)
    );

    cp0_regs u_cp0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .cur_valid   (cur_valid),
        .cur_item    (cur_item),
        .ext_int     (ext_int),
        .rdata       (cp0_rdata),
        .int_pending (int_pending)
    );

    wb_result_select u_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .cur_valid  (cur_valid),
        .cur_item   (cur_item),
        .align_data (align_data),
        .merge_data (merge_data),
        .merge_be   (merge_be),
        .cp0_rdata  (cp0_rdata),
        .rf_wr      (rf_wr),
        .flush      (flush),
        .trace      (trace)
    );

endmodule

//--- wb_stage.f
+incdir+verilog
verilog/wb_pkg.sv
verilog/wb_input_latch.sv
verilog/load_align.sv
verilog/load_merge.sv
verilog/cp0_regs.sv
verilog/wb_result_select.sv
verilog/wb_stage.sv
tests/wb_stage_tb.sv
